// ==== hdl/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Instruction word coming from IR
`define CU_INS_W 8

// Registers reachable through the write, increment and reset masks
`define CU_REG_COUNT 14

// Bit position of each register inside a mask
`define CU_RO_PC 0
`define CU_RO_IR 1
`define CU_RO_GSP 2
`define CU_RO_RP 3
`define CU_RO_CP 4
`define CU_RO_STP 5
`define CU_RO_CID 6
`define CU_RO_EOPC 7
`define CU_RO_MC 8
`define CU_RO_MV 9
`define CU_RO_WV 10
`define CU_RO_MULR 11
`define CU_RO_ADDR 12
`define CU_RO_AC 13

`endif

// ==== hdl/controlPkg.sv ====
`include "cpu_config.svh"

package controlPkg;

	// Opcodes as fetched into IR, halt first
	typedef enum logic [`CU_INS_W-1:0] {
		opHalt = 8'd1,
		opRstAll,
		opRstAc,
		opRstAddr,
		opRstGsp,
		opRstMc,
		opRstCp,
		opRstRp,
		opIncGsp,
		opIncAc,
		opIncCp,
		opIncRp,
		opIncMc,
		opIncStp,
		opLdAddr,
		opLdAc,
		opLdMulr,
		opLdRp,
		opLdCp,
		opStStp,
		opAdd,
		opMul1,
		opMul2,
		opDiv,
		opMod,
		opMStp, opMRp, opMCp, opMWv,
		opMEopc, opMAddr, opMCid, opMMv,
		opMCidAc, opMRpAc, opMCpAc, opMStpAc,
		opJmp,
		opJmpZ1,
		opJmpZ2
	} opcodeT;

	// Every microstep; the branch steps stay at the end
	typedef enum logic [5:0] {
		stFetch1, stFetch2,
		stHalt,
		stRstAll, stRstAc, stRstAddr, stRstGsp, stRstMc, stRstCp, stRstRp,
		stIncGsp, stIncAc, stIncCp, stIncRp, stIncMc, stIncStp,
		stLdAddr1, stLdAddr2,
		stLdAc1, stLdAc2,
		stLdMulr1, stLdMulr2,
		stLdRp1, stLdRp2,
		stLdCp1, stLdCp2,
		stStStp,
		stAdd, stMul1, stMul2, stDiv, stMod,
		stMStp, stMRp, stMCp, stMWv, stMEopc, stMAddr, stMCid, stMMv,
		stMCidAc, stMRpAc, stMCpAc, stMStpAc,
		stJmp1, stJmp2, stJmp3, stJmp4,
		stJmpZ1, stJmpZ2,
		stJmpZ1Y1, stJmpZ1Y2, stJmpZ1Y3,
		stJmpZ1N1, stJmpZ1N2,
		stJmpZ2Y1, stJmpZ2Y2, stJmpZ2Y3,
		stJmpZ2N1, stJmpZ2N2
	} stepT;

	typedef enum logic [2:0] {
		aluNone, aluAdd, aluMul, aluDiv, aluMod
	} aluOpT;

	// Source driving the internal bus
	typedef enum logic [3:0] {
		busMemout, busAc, busAddr, busMulr, busMv,
		busWv, busCid, busRp, busCp, busStp
	} busSelT;

	// Memory address pointer
	typedef enum logic [1:0] {
		ptrGsp, ptrRp, ptrCp, ptrStp
	} ptrSelT;

	typedef enum logic [1:0] {
		memIdle, memRead, memWrite
	} memCtrlT;

	typedef logic [`CU_REG_COUNT-1:0] regMaskT;

	typedef struct packed {
		aluOpT aluOp;
		busSelT busSel;
		ptrSelT ptrSel;
		memCtrlT memCtrl;
		regMaskT wrtEn;
		regMaskT incEn;
		regMaskT rstEn;
	} ctrlWordT;

	// Nothing driven, bus parked on AC
	localparam ctrlWordT ctrlIdle = '{
		aluOp: aluNone,
		busSel: busAc,
		ptrSel: ptrGsp,
		memCtrl: memIdle,
		wrtEn: '0,
		incEn: '0,
		rstEn: '0
	};

	// Mask with a single register selected
	function automatic regMaskT regBit(input int unsigned idx);
		return regMaskT'(1) << idx;
	endfunction

endpackage

// ==== hdl/opcodeDecoder.sv ====
`timescale 1ns/1ps

module opcodeDecoder (
	input controlPkg::opcodeT ins,
	output controlPkg::stepT entryStep
);
	import controlPkg::*;

	always_comb begin
		case (ins)
			opHalt: entryStep = stHalt;
			opRstAll: entryStep = stRstAll;
			opRstAc: entryStep = stRstAc;
			opRstAddr: entryStep = stRstAddr;
			opRstGsp: entryStep = stRstGsp;
			opRstMc: entryStep = stRstMc;
			opRstCp: entryStep = stRstCp;
			opRstRp: entryStep = stRstRp;
			opIncGsp: entryStep = stIncGsp;
			opIncAc: entryStep = stIncAc;
			opIncCp: entryStep = stIncCp;
			opIncRp: entryStep = stIncRp;
			opIncMc: entryStep = stIncMc;
			opIncStp: entryStep = stIncStp;
			// Loads enter on their memory read step
			opLdAddr: entryStep = stLdAddr1;
			opLdAc: entryStep = stLdAc1;
			opLdMulr: entryStep = stLdMulr1;
			opLdRp: entryStep = stLdRp1;
			opLdCp: entryStep = stLdCp1;
			opStStp: entryStep = stStStp;
			opAdd: entryStep = stAdd;
			opMul1: entryStep = stMul1;
			opMul2: entryStep = stMul2;
			opDiv: entryStep = stDiv;
			opMod: entryStep = stMod;
			opMStp: entryStep = stMStp;
			opMRp: entryStep = stMRp;
			opMCp: entryStep = stMCp;
			opMWv: entryStep = stMWv;
			opMEopc: entryStep = stMEopc;
			opMAddr: entryStep = stMAddr;
			opMCid: entryStep = stMCid;
			opMMv: entryStep = stMMv;
			opMCidAc: entryStep = stMCidAc;
			opMRpAc: entryStep = stMRpAc;
			opMCpAc: entryStep = stMCpAc;
			opMStpAc: entryStep = stMStpAc;
			opJmp: entryStep = stJmp1;
			// Conditional jumps start on the flag test
			opJmpZ1: entryStep = stJmpZ1;
			opJmpZ2: entryStep = stJmpZ2;
			// Unknown code goes straight back to fetch
			default: entryStep = stFetch1;
		endcase
	end

endmodule

// ==== hdl/stepSequencer.sv ====
`timescale 1ns/1ps

module stepSequencer (
	input logic clk,
	input logic rst,
	input controlPkg::stepT entryStep,
	input logic z1,
	input logic z2,
	output controlPkg::stepT step
);
	import controlPkg::*;

	stepT nextStep;

	always_comb begin
		case (step)
			stFetch1: nextStep = stFetch2;
			stFetch2: nextStep = entryStep;
			// Stuck here until reset
			stHalt: nextStep = stHalt;

			stLdAddr1: nextStep = stLdAddr2;
			stLdAc1: nextStep = stLdAc2;
			stLdMulr1: nextStep = stLdMulr2;
			stLdRp1: nextStep = stLdRp2;
			stLdCp1: nextStep = stLdCp2;

			stJmp1: nextStep = stJmp2;
			stJmp2: nextStep = stJmp3;
			stJmp3: nextStep = stJmp4;

			// Flag sampled in the test cycle itself
			stJmpZ1: nextStep = z1 ? stJmpZ1Y1 : stJmpZ1N1;
			stJmpZ1Y1: nextStep = stJmpZ1Y2;
			stJmpZ1Y2: nextStep = stJmpZ1Y3;
			stJmpZ1N1: nextStep = stJmpZ1N2;

			// Z2 branch is taken on a low flag
			stJmpZ2: nextStep = z2 ? stJmpZ2N1 : stJmpZ2Y1;
			stJmpZ2Y1: nextStep = stJmpZ2Y2;
			stJmpZ2Y2: nextStep = stJmpZ2Y3;
			stJmpZ2N1: nextStep = stJmpZ2N2;

			// Last step of every sequence
			default: nextStep = stFetch1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= stFetch1;
		end else begin
			step <= nextStep;
		end
	end

	// Step register stays inside the encoded range once out of reset
	stepInRange: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown(step) && (step <= stJmpZ2N2)
	) else $error("step register left the microstep range");

endmodule

// ==== hdl/microcodeTable.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module microcodeTable (
	input logic clk,
	input logic rst,
	input controlPkg::stepT step,
	output controlPkg::ctrlWordT ctrl
);
	import controlPkg::*;

	ctrlWordT nextCtrl;

	always_comb begin
		nextCtrl = ctrlIdle;
		case (step)
			stFetch2: begin
				nextCtrl.incEn = regBit(`CU_RO_PC);
				nextCtrl.wrtEn = regBit(`CU_RO_IR);
			end

			// Everything except PC and IR
			stRstAll: nextCtrl.rstEn = ~(regBit(`CU_RO_PC) | regBit(`CU_RO_IR));
			stRstAc: nextCtrl.rstEn = regBit(`CU_RO_AC);
			stRstAddr: nextCtrl.rstEn = regBit(`CU_RO_ADDR);
			stRstGsp: nextCtrl.rstEn = regBit(`CU_RO_GSP);
			stRstMc: nextCtrl.rstEn = regBit(`CU_RO_MC);
			stRstCp: nextCtrl.rstEn = regBit(`CU_RO_CP);
			stRstRp: nextCtrl.rstEn = regBit(`CU_RO_RP);

			stIncGsp: nextCtrl.incEn = regBit(`CU_RO_GSP);
			stIncAc: nextCtrl.incEn = regBit(`CU_RO_AC);
			stIncCp: nextCtrl.incEn = regBit(`CU_RO_CP);
			stIncRp: nextCtrl.incEn = regBit(`CU_RO_RP);
			stIncMc: nextCtrl.incEn = regBit(`CU_RO_MC);
			stIncStp: nextCtrl.incEn = regBit(`CU_RO_STP);

			// Read through GSP
			stLdAddr1, stLdAc1, stLdMulr1: nextCtrl.memCtrl = memRead;
			stLdRp1: begin
				nextCtrl.ptrSel = ptrRp;
				nextCtrl.memCtrl = memRead;
			end
			stLdCp1: begin
				nextCtrl.ptrSel = ptrCp;
				nextCtrl.memCtrl = memRead;
			end

			// Memory data onto the bus
			stLdAddr2: begin
				nextCtrl.busSel = busMemout;
				nextCtrl.wrtEn = regBit(`CU_RO_ADDR);
			end
			stLdAc2, stLdCp2: begin
				nextCtrl.busSel = busMemout;
				nextCtrl.wrtEn = regBit(`CU_RO_AC);
			end
			stLdMulr2, stLdRp2: begin
				nextCtrl.busSel = busMemout;
				nextCtrl.wrtEn = regBit(`CU_RO_MULR);
			end

			stStStp: begin
				nextCtrl.ptrSel = ptrStp;
				nextCtrl.memCtrl = memWrite;
			end

			stAdd: begin
				nextCtrl.aluOp = aluAdd;
				nextCtrl.busSel = busAddr;
			end
			stMul1: begin
				nextCtrl.aluOp = aluMul;
				nextCtrl.busSel = busMulr;
			end
			stMul2: begin
				nextCtrl.aluOp = aluMul;
				nextCtrl.busSel = busMv;
			end
			stDiv: begin
				nextCtrl.aluOp = aluDiv;
				nextCtrl.busSel = busWv;
			end
			stMod: begin
				nextCtrl.aluOp = aluMod;
				nextCtrl.busSel = busWv;
			end

			// AC already sits on the bus
			stMStp: nextCtrl.wrtEn = regBit(`CU_RO_STP);
			stMRp: nextCtrl.wrtEn = regBit(`CU_RO_RP);
			stMCp: nextCtrl.wrtEn = regBit(`CU_RO_CP);
			stMWv: nextCtrl.wrtEn = regBit(`CU_RO_WV);
			stMEopc: nextCtrl.wrtEn = regBit(`CU_RO_EOPC);
			stMAddr: nextCtrl.wrtEn = regBit(`CU_RO_ADDR);
			stMCid: nextCtrl.wrtEn = regBit(`CU_RO_CID);
			stMMv: nextCtrl.wrtEn = regBit(`CU_RO_MV);

			stMCidAc: begin
				nextCtrl.busSel = busCid;
				nextCtrl.wrtEn = regBit(`CU_RO_AC);
			end
			stMRpAc: begin
				nextCtrl.busSel = busRp;
				nextCtrl.wrtEn = regBit(`CU_RO_AC);
			end
			stMCpAc: begin
				nextCtrl.busSel = busCp;
				nextCtrl.wrtEn = regBit(`CU_RO_AC);
			end
			stMStpAc: begin
				nextCtrl.busSel = busStp;
				nextCtrl.wrtEn = regBit(`CU_RO_AC);
			end

			stJmp3, stJmpZ1Y2, stJmpZ2Y2: nextCtrl.wrtEn = regBit(`CU_RO_PC);
			stJmpZ1Y1, stJmpZ2Y1: nextCtrl.wrtEn = regBit(`CU_RO_IR);
			// Skip the target word
			stJmpZ1N1, stJmpZ2N1: begin
				nextCtrl.incEn = regBit(`CU_RO_PC);
				nextCtrl.wrtEn = regBit(`CU_RO_IR);
			end

			// fetch1, halt, flag tests and padding steps
			default: nextCtrl = ctrlIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl <= ctrlIdle;
		end else begin
			ctrl <= nextCtrl;
		end
	end

	// Only one counter moves per cycle
	singleInc: assert property (
		@(posedge clk) disable iff (rst) $onehot0(ctrl.incEn)
	) else $error("more than one increment enable active");

	noWrtRstClash: assert property (
		@(posedge clk) disable iff (rst) (ctrl.wrtEn & ctrl.rstEn) == '0
	) else $error("register written and reset in the same cycle");

	// Stores only go through the stack pointer
	writeViaStp: assert property (
		@(posedge clk) disable iff (rst) (ctrl.memCtrl == memWrite) |-> (ctrl.ptrSel == ptrStp)
	) else $error("memory write with a pointer other than STP");

endmodule

// ==== hdl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input logic clk,
	input logic rst,
	input controlPkg::opcodeT ins,
	input logic z1,
	input logic z2,
	output controlPkg::ctrlWordT ctrl
);
	import controlPkg::*;

	stepT entryStep;
	stepT step;

	opcodeDecoder decoder_i (
		.ins(ins),
		.entryStep(entryStep)
	);

	// Step register and branch choice
	stepSequencer sequencer_i (
		.clk(clk),
		.rst(rst),
		.entryStep(entryStep),
		.z1(z1),
		.z2(z2),
		.step(step)
	);

	// Control word lags the step by one clock
	microcodeTable ucodeTable_i (
		.clk(clk),
		.rst(rst),
		.step(step),
		.ctrl(ctrl)
	);

endmodule

// ==== bench/controlModel.svh ====
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

localparam int phFetch1 = 0;
localparam int phFetch2 = 1;
localparam int phExec = 2;
localparam int phHalted = 3;

int mPhase;
opcodeT mOp;
int mIdx;
logic mTaken;
ctrlWordT expCtrl;

function automatic regMaskT maskAt(input int pos);
	return regMaskT'(1) << pos;
endfunction

// Register named by a single-target instruction
function automatic int targetOf(input opcodeT op);
	case (op)
		opRstAc, opIncAc, opLdAc, opLdCp: return `CU_RO_AC;
		opRstAddr, opLdAddr, opMAddr: return `CU_RO_ADDR;
		opRstGsp, opIncGsp: return `CU_RO_GSP;
		opRstMc, opIncMc: return `CU_RO_MC;
		opRstCp, opIncCp, opMCp: return `CU_RO_CP;
		opRstRp, opIncRp, opMRp: return `CU_RO_RP;
		opIncStp, opMStp: return `CU_RO_STP;
		opLdMulr, opLdRp: return `CU_RO_MULR;
		opMWv: return `CU_RO_WV;
		opMEopc: return `CU_RO_EOPC;
		opMCid: return `CU_RO_CID;
		opMMv: return `CU_RO_MV;
		default: return `CU_RO_PC;
	endcase
endfunction

function automatic int execLength(input opcodeT op, input logic taken);
	case (op)
		opLdAddr, opLdAc, opLdMulr, opLdRp, opLdCp: return 2;
		opJmp: return 4;
		opJmpZ1, opJmpZ2: return taken ? 4 : 3;
		default: return 1;
	endcase
endfunction

function automatic ctrlWordT expectedWord(input int phase, input opcodeT op, input int idx,
		input logic taken);
	ctrlWordT w;
	w = '{aluNone, busAc, ptrGsp, memIdle, '0, '0, '0};
	if (phase == phFetch2) begin
		w.incEn = maskAt(`CU_RO_PC);
		w.wrtEn = maskAt(`CU_RO_IR);
	end else if (phase == phExec) begin
		case (op)
			opRstAll: begin
				for (int i = 2; i < `CU_REG_COUNT; i++)
					w.rstEn[i] = 1'b1;
			end
			opRstAc, opRstAddr, opRstGsp, opRstMc, opRstCp, opRstRp:
				w.rstEn = maskAt(targetOf(op));
			opIncGsp, opIncAc, opIncCp, opIncRp, opIncMc, opIncStp:
				w.incEn = maskAt(targetOf(op));
			opLdAddr, opLdAc, opLdMulr, opLdRp, opLdCp: begin
				if (idx == 0) begin
					w.memCtrl = memRead;
					w.ptrSel = (op == opLdRp) ? ptrRp : (op == opLdCp) ? ptrCp : ptrGsp;
				end else begin
					w.busSel = busMemout;
					w.wrtEn = maskAt(targetOf(op));
				end
			end
			opStStp: begin
				w.memCtrl = memWrite;
				w.ptrSel = ptrStp;
			end
			opAdd, opMul1, opMul2, opDiv, opMod: begin
				w.aluOp = (op == opAdd) ? aluAdd : (op == opDiv) ? aluDiv :
					(op == opMod) ? aluMod : aluMul;
				w.busSel = (op == opAdd) ? busAddr : (op == opMul1) ? busMulr :
					(op == opMul2) ? busMv : busWv;
			end
			opMStp, opMRp, opMCp, opMWv, opMEopc, opMAddr, opMCid, opMMv:
				w.wrtEn = maskAt(targetOf(op));
			opMCidAc, opMRpAc, opMCpAc, opMStpAc: begin
				w.busSel = (op == opMCidAc) ? busCid : (op == opMRpAc) ? busRp :
					(op == opMCpAc) ? busCp : busStp;
				w.wrtEn = maskAt(`CU_RO_AC);
			end
			opJmp: if (idx == 2) w.wrtEn = maskAt(`CU_RO_PC);
			opJmpZ1, opJmpZ2: begin
				if (idx == 1) begin
					w.wrtEn = maskAt(`CU_RO_IR);
					if (!taken) w.incEn = maskAt(`CU_RO_PC);
				end else if (idx == 2 && taken) begin
					w.wrtEn = maskAt(`CU_RO_PC);
				end
			end
			default: ;
		endcase
	end
	return w;
endfunction

task automatic modelReset();
	mPhase = phFetch1;
	mIdx = 0;
	mTaken = 1'b0;
	expCtrl = expectedWord(phHalted, opHalt, 0, 1'b0);
endtask

// One clock edge; the word of the current step becomes the expected output
task automatic modelStep(input logic [7:0] code, input logic z1v, input logic z2v);
	expCtrl = expectedWord(mPhase, mOp, mIdx, mTaken);
	case (mPhase)
		phFetch1: mPhase = phFetch2;
		phFetch2: begin
			mOp = opcodeT'(code);
			mIdx = 0;
			if (code == opHalt)
				mPhase = phHalted;
			else if (code > opHalt && code <= opJmpZ2)
				mPhase = phExec;
			else
				mPhase = phFetch1;
		end
		phExec: begin
			if (mIdx == 0)
				mTaken = (mOp == opJmpZ1) ? z1v : !z2v;
			mIdx++;
			if (mIdx >= execLength(mOp, mTaken))
				mPhase = phFetch1;
		end
		default: mPhase = phHalted;
	endcase
endtask

`endif

// ==== bench/controlUnitTb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module controlUnitTb;
	import controlPkg::*;

	`include "controlModel.svh"

	localparam int numInstr = 300;
	localparam int resetCycles = 16;
	localparam real watchdogNs = (numInstr * 6 * 10.0 + resetCycles * 10.0) * 2.0;

	logic clk;
	logic rst;
	opcodeT ins;
	logic z1;
	logic z2;
	ctrlWordT ctrl;
	logic [15:0] lfsr;

	controlUnit dut_i (
		.clk(clk),
		.rst(rst),
		.ins(ins),
		.z1(z1),
		.z2(z2),
		.ctrl(ctrl)
	);

	always #5 clk = ~clk;

	// Inputs are stable here since they change on the falling edge
	always @(posedge clk) begin
		if (rst)
			modelReset();
		else
			modelStep(ins, z1, z2);
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawBits(input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic checkCtrl(input ctrlWordT expWord, input ctrlWordT gotWord);
		string fields;
		fields = "";
		if (gotWord.aluOp !== expWord.aluOp) fields = {fields, " aluOp"};
		if (gotWord.busSel !== expWord.busSel) fields = {fields, " busSel"};
		if (gotWord.ptrSel !== expWord.ptrSel) fields = {fields, " ptrSel"};
		if (gotWord.memCtrl !== expWord.memCtrl) fields = {fields, " memCtrl"};
		if (gotWord.wrtEn !== expWord.wrtEn) fields = {fields, " wrtEn"};
		if (gotWord.incEn !== expWord.incEn) fields = {fields, " incEn"};
		if (gotWord.rstEn !== expWord.rstEn) fields = {fields, " rstEn"};
		if (fields != "") begin
			$display("FAILED at %0t ns: ctrl differs in%s, expected %h, got %h",
				$time, fields, expWord, gotWord);
			$display("TEST RESULT: FAIL");
			$fatal(1, "control word mismatch");
		end
	endtask

	// About one draw in sixteen is a code outside the opcode set
	task automatic drawOpcode(output opcodeT op);
		logic [31:0] r;
		drawBits(4, r);
		if (r == 0) begin
			drawBits(8, r);
			op = opcodeT'(8'd41 + 8'(r % 215));
		end else begin
			drawBits(6, r);
			op = opcodeT'(8'd2 + 8'(r % 39));
		end
	endtask

	initial begin
		int issued;
		logic [31:0] r;
		lfsr = 16'd61178;
		clk = 1'b0;
		rst = 1'b1;
		ins = opRstAll;
		z1 = 1'b0;
		z2 = 1'b0;
		issued = 0;
		modelReset();
		repeat (resetCycles) begin
			@(negedge clk);
			checkCtrl(expCtrl, ctrl);
		end
		rst = 1'b0;
		while (issued < numInstr) begin
			@(negedge clk);
			checkCtrl(expCtrl, ctrl);
			// Halt goes last so the run can end in it
			if (mPhase == phFetch2 && issued == numInstr - 1)
				ins = opHalt;
			else
				drawOpcode(ins);
			if (mPhase == phFetch2)
				issued++;
			drawBits(1, r);
			z1 = r[0];
			drawBits(1, r);
			z2 = r[0];
		end
		repeat (22) begin
			@(negedge clk);
			checkCtrl(expCtrl, ctrl);
			drawBits(2, r);
			z1 = r[0];
			z2 = r[1];
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("Timeout: the test did not finish within %0t", $time);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== tb.f ====
+incdir+hdl
+incdir+bench
hdl/controlPkg.sv
hdl/opcodeDecoder.sv
hdl/stepSequencer.sv
hdl/microcodeTable.sv
hdl/controlUnit.sv
bench/controlUnitTb.sv
